//--- flist.f
+incdir+src
src/lsu_pkg.sv
src/axi_lite_if.sv
src/lsu_core.sv
src/sram_axi_slave.sv
src/lsu_top.sv
test/lsu_assert.sv
test/lsu_tb.sv

//--- test/lsu_tests.txt
# columns: op addr wdata exp_rdata exp_err, all in hex
# op codes: 0 lb, 1 lh, 2 lw, 3 lbu, 4 lhu, 5 sb, 6 sh, 7 sw
7 80000000 a1b2c3d4 00000000 0
2 80000000 00000000 a1b2c3d4 0
5 80000001 0000005e 00000000 0
6 80000002 00008f17 00000000 0
2 80000000 00000000 8f175ed4 0
0 80000000 00000000 ffffffd4 0
0 80000001 00000000 0000005e 0
0 80000002 00000000 00000017 0
0 80000003 00000000 ffffff8f 0
3 80000003 00000000 0000008f 0
1 80000000 00000000 00005ed4 0
1 80000002 00000000 ffff8f17 0
4 80000002 00000000 00008f17 0
7 80000004 807f80ff 00000000 0
3 80000004 00000000 000000ff 0
0 80000005 00000000 ffffff80 0
4 80000004 00000000 000080ff 0
1 80000006 00000000 ffff807f 0
1 80000001 00000000 00000000 1
2 80000002 00000000 00000000 1
6 80000003 0000ffff 00000000 1
7 80000001 deadbeef 00000000 1
2 80000000 00000000 8f175ed4 0
2 80000004 00000000 807f80ff 0

//--- test/lsu_tb.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_tb import lsu_pkg::*; ();

    logic                   clk;
    logic                   rst;
    logic                   req_valid;
    lsu_op_e                req_op;
    logic [`LSU_ADDR_W-1:0] req_addr;
    logic [`LSU_ADDR_W-1:0] req_wdata;
    logic                   req_ready;
    logic                   resp_valid;
    logic [`LSU_ADDR_W-1:0] resp_rdata;
    logic                   resp_err;
    logic                   resp_ready;

    // one entry per file line
    logic [2:0]             q_op[$];
    logic [`LSU_ADDR_W-1:0] q_addr[$];
    logic [`LSU_ADDR_W-1:0] q_wdata[$];
    logic [`LSU_ADDR_W-1:0] q_rdata[$];
    logic                   q_err[$];
    int                     num_tests;
    logic                   tests_loaded;

    lsu_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .resp_err   (resp_err),
        .resp_ready (resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // comment lines do not scan as hex and drop out
    task automatic load_tests();
        int                     fd;
        int                     rc;
        string                  line;
        logic [2:0]             f_op;
        logic [`LSU_ADDR_W-1:0] f_addr;
        logic [`LSU_ADDR_W-1:0] f_wdata;
        logic [`LSU_ADDR_W-1:0] f_rdata;
        logic                   f_err;
        fd = $fopen("test/lsu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            $display("Simulation FAILED");
            $fatal(1, "no test data");
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            // nothing more to read
            if (rc == 0)
                break;
            if ($sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_wdata, f_rdata, f_err) == 5) begin
                q_op.push_back(f_op);
                q_addr.push_back(f_addr);
                q_wdata.push_back(f_wdata);
                q_rdata.push_back(f_rdata);
                q_err.push_back(f_err);
            end
        end
        $fclose(fd);
        num_tests = q_op.size();
        if (num_tests == 0) begin
            $display("the test data file holds no requests");
            $display("Simulation FAILED");
            $fatal(1, "empty test data");
        end
    endtask

    // issue one request, then collect its response under random stalls
    task automatic run_request(input int idx);
        logic got_resp;
        req_valid = 1'b1;
        req_op    = lsu_op_e'(q_op[idx]);
        req_addr  = q_addr[idx];
        req_wdata = q_wdata[idx];
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        // accepted on this edge
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        got_resp  = 1'b0;
        while (!got_resp) begin
            // stall roughly one cycle in four
            resp_ready = ($urandom_range(0, 3) != 0);
            if (resp_valid && resp_ready) begin
                check_value("resp_rdata", resp_rdata, q_rdata[idx]);
                check_value("resp_err", {31'b0, resp_err}, {31'b0, q_err[idx]});
                got_resp = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        // taken once, must be gone now
        check_value("resp_valid", {31'b0, resp_valid}, 32'd0);
    endtask

    // bound checker counts its assertion failures
    always @(negedge clk) begin
        if (dut_i.u_core.u_assert.fail_count != 0) begin
            $display("a bus or response protocol assertion failed");
            $display("Simulation FAILED");
            $fatal(1, "protocol assertion failed");
        end
    end

    initial begin
        void'($urandom(28374));
        tests_loaded = 1'b0;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req_op       = LB;
        req_addr     = '0;
        req_wdata    = '0;
        resp_ready   = 1'b0;
        load_tests();
        tests_loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("req_ready", {31'b0, req_ready}, 32'd1);
        check_value("resp_valid", {31'b0, resp_valid}, 32'd0);
        for (int i = 0; i < num_tests; i++)
            run_request(i);
        if (dut_i.u_core.u_assert.fail_count != 0) begin
            $display("a bus or response protocol assertion failed");
            $display("Simulation FAILED");
            $fatal(1, "protocol assertion failed");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    // budget scales with the number of requests
    initial begin
        wait (tests_loaded);
        repeat (num_tests * (`LSU_RD_LAT + 20) + 10) @(posedge clk);
        $display("timeout, the run did not finish in the expected number of cycles");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- test/lsu_assert.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_assert (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_ready,
    input  logic                   req_fire,
    input  logic                   misaligned,
    input  logic                   resp_valid,
    input  logic [`LSU_ADDR_W-1:0] resp_rdata,
    input  logic                   resp_err,
    input  logic                   resp_ready,
    axi_lite_if.master             bus
);

    // failed assertions so far
    int unsigned fail_count = 0;

    // valids and payloads hold until their handshake
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        bus.arvalid && !bus.arready |=> bus.arvalid && $stable(bus.araddr))
        else begin
            fail_count++;
            $error("ar channel changed before handshake");
        end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        bus.awvalid && !bus.awready |=> bus.awvalid && $stable(bus.awaddr))
        else begin
            fail_count++;
            $error("aw channel changed before handshake");
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        bus.wvalid && !bus.wready |=> bus.wvalid && $stable(bus.wdata) && $stable(bus.wstrb))
        else begin
            fail_count++;
            $error("w channel changed before handshake");
        end

    r_hold: assert property (@(posedge clk) disable iff (rst)
        bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata))
        else begin
            fail_count++;
            $error("r channel changed before handshake");
        end

    b_hold: assert property (@(posedge clk) disable iff (rst)
        bus.bvalid && !bus.bready |=> bus.bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before handshake");
        end

    // response held under back-pressure
    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata) && $stable(resp_err))
        else begin
            fail_count++;
            $error("response changed while stalled");
        end

    // no new request while one is pending
    busy_no_req: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> !req_ready)
        else begin
            fail_count++;
            $error("request accepted while response pending");
        end

    // fault goes straight to response, bus untouched
    misaligned_no_bus: assert property (@(posedge clk) disable iff (rst)
        req_fire && misaligned |=> resp_valid && resp_err &&
        !bus.arvalid && !bus.awvalid && !bus.wvalid)
        else begin
            fail_count++;
            $error("bus access on a misaligned request");
        end

endmodule

bind lsu_core lsu_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .req_ready  (req_ready),
    .req_fire   (req_fire),
    .misaligned (misaligned),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_err   (resp_err),
    .resp_ready (resp_ready),
    .bus        (bus)
);

//--- src/lsu_top.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_top import lsu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // request from execute
    input  logic                   req_valid,
    input  lsu_op_e                req_op,
    input  logic [`LSU_ADDR_W-1:0] req_addr,
    input  logic [`LSU_ADDR_W-1:0] req_wdata,
    output logic                   req_ready,
    // load data or fault back to execute
    output logic                   resp_valid,
    output logic [`LSU_ADDR_W-1:0] resp_rdata,
    output logic                   resp_err,
    input  logic                   resp_ready
);

    // data memory bus between core and sram
    axi_lite_if bus_if ();

    lsu_core u_core (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .resp_err   (resp_err),
        .resp_ready (resp_ready),
        .bus        (bus_if.master)
    );

    // single-port sram behind the bus
    sram_axi_slave u_sram (
        .clk (clk),
        .rst (rst),
        .bus (bus_if.slave)
    );

endmodule

//--- src/sram_axi_slave.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module sram_axi_slave import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    axi_lite_if.slave  bus
);

    localparam int STRB_W = `LSU_ADDR_W / 8;
    localparam int IDX_W  = $clog2(`LSU_SRAM_DEPTH);
    localparam int CNT_W  = $clog2(`LSU_RD_LAT + 1);

    // word array, contents undefined until written
    logic [`LSU_ADDR_W-1:0] mem [`LSU_SRAM_DEPTH];

    // read side
    rd_state_e              rd_state;
    logic [CNT_W-1:0]       rd_cnt;
    logic [`LSU_ADDR_W-1:0] rd_word;
    logic                   ar_fire;
    logic                   r_fire;

    // write side
    logic                   wr_pend;
    logic                   bvalid_q;
    logic [IDX_W-1:0]       wr_idx;
    logic [`LSU_ADDR_W-1:0] wr_data;
    logic [STRB_W-1:0]      wr_strb;
    logic                   aw_fire;
    logic                   b_fire;

    // byte address to word index
    // bits above the byte offset, wrapping inside the array
    function automatic logic [IDX_W-1:0] word_idx(input logic [`LSU_ADDR_W-1:0] addr);
        logic [`LSU_ADDR_W-1:0] offs;
        offs = addr - `LSU_MEM_BASE;
        return offs[IDX_W+1:2];
    endfunction

    assign ar_fire = bus.arvalid && bus.arready;
    assign r_fire  = bus.rvalid && bus.rready;

    // address only taken while nothing is in flight on the read side
    assign bus.arready = (rd_state == RD_IDLE);
    assign bus.rvalid  = (rd_state == RD_VALID);
    assign bus.rdata   = rd_word;

    // countdown models slow sram access
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= RD_IDLE;
            rd_cnt   <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        rd_state <= RD_WAIT;
                        rd_cnt   <= CNT_W'(`LSU_RD_LAT - 1);
                    end
                end
                RD_WAIT: begin
                    // spends LSU_RD_LAT cycles here
                    if (rd_cnt == '0)
                        rd_state <= RD_VALID;
                    else
                        rd_cnt <= rd_cnt - 1'b1;
                end
                RD_VALID: begin
                    // arready comes back the cycle after this
                    if (r_fire)
                        rd_state <= RD_IDLE;
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // word grabbed at address accept, so rdata holds through the wait
    always_ff @(posedge clk) begin
        if (ar_fire)
            rd_word <= mem[word_idx(bus.araddr)];
    end

    // aw and w only accepted together
    assign aw_fire     = bus.awvalid && bus.wvalid && bus.awready && bus.wready;
    assign b_fire      = bus.bvalid && bus.bready;

    // busy from accept until b handshake
    assign bus.awready = !(wr_pend || bvalid_q);
    assign bus.wready  = !(wr_pend || bvalid_q);
    assign bus.bvalid  = bvalid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_pend  <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (aw_fire)
                wr_pend <= 1'b1;
            else if (wr_pend)
                wr_pend <= 1'b0;
            // response follows the commit cycle
            if (wr_pend)
                bvalid_q <= 1'b1;
            else if (b_fire)
                bvalid_q <= 1'b0;
        end
    end

    // write request register
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_idx  <= word_idx(bus.awaddr);
            wr_data <= bus.wdata;
            wr_strb <= bus.wstrb;
        end
    end

    // commit stage, only strobed lanes change
    always_ff @(posedge clk) begin
        if (wr_pend) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wr_strb[i])
                    mem[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
            end
        end
    end

endmodule

//--- src/lsu_core.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_core import lsu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  lsu_op_e                req_op,
    input  logic [`LSU_ADDR_W-1:0] req_addr,
    input  logic [`LSU_ADDR_W-1:0] req_wdata,
    output logic                   req_ready,
    output logic                   resp_valid,
    output logic [`LSU_ADDR_W-1:0] resp_rdata,
    output logic                   resp_err,
    input  logic                   resp_ready,
    axi_lite_if.master             bus
);

    localparam int STRB_W = `LSU_ADDR_W / 8;

    lsu_state_e             state;
    lsu_op_e                op_q;
    logic [`LSU_ADDR_W-1:0] addr_q;
    logic [`LSU_ADDR_W-1:0] wdata_q;
    logic [STRB_W-1:0]      strb_q;

    logic                   req_fire;
    logic                   misaligned;
    logic                   is_load;
    logic [`LSU_ADDR_W-1:0] lane_wdata;
    logic [STRB_W-1:0]      lane_strb;
    logic [`LSU_ADDR_W-1:0] rd_shift;
    logic [`LSU_ADDR_W-1:0] load_data;

    // one request at a time, only taken when idle
    assign req_ready = (state == IDLE);
    assign req_fire  = req_valid && req_ready;
    assign is_load   = (req_op inside {LB, LH, LW, LBU, LHU});

    // halves need even address, words need both low bits clear
    always_comb begin
        case (req_op)
            LH, LHU, SH: misaligned = req_addr[0];
            LW, SW:      misaligned = |req_addr[1:0];
            default:     misaligned = 1'b0;
        endcase
    end

    // move store data onto its byte lane and mark the lanes written
    always_comb begin
        case (req_op)
            SB: begin
                lane_wdata = {24'b0, req_wdata[7:0]} << {req_addr[1:0], 3'b000};
                lane_strb  = 4'b0001 << req_addr[1:0];
            end
            SH: begin
                lane_wdata = {16'b0, req_wdata[15:0]} << {req_addr[1], 4'b0000};
                lane_strb  = 4'b0011 << {req_addr[1], 1'b0};
            end
            SW: begin
                lane_wdata = req_wdata;
                lane_strb  = 4'b1111;
            end
            default: begin
                // loads write nothing
                lane_wdata = req_wdata;
                lane_strb  = 4'b0000;
            end
        endcase
    end

    // addressed byte or half down to bit 0, then extend per opcode
    assign rd_shift = bus.rdata >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (op_q)
            LB:      load_data = {{24{rd_shift[7]}}, rd_shift[7:0]};
            LBU:     load_data = {24'b0, rd_shift[7:0]};
            LH:      load_data = {{16{rd_shift[15]}}, rd_shift[15:0]};
            LHU:     load_data = {16'b0, rd_shift[15:0]};
            default: load_data = bus.rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            resp_err <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_fire) begin
                        resp_err <= misaligned;
                        // bad alignment skips the bus entirely
                        if (misaligned)
                            state <= RESP;
                        else if (is_load)
                            state <= RD_ADDR;
                        else
                            state <= WR_REQ;
                    end
                end
                RD_ADDR: if (bus.arready) state <= RD_DATA;
                RD_DATA: if (bus.rvalid) state <= RESP;
                // aw and w go out together, slave takes both in one cycle
                WR_REQ:  if (bus.awready && bus.wready) state <= WR_RESP;
                WR_RESP: if (bus.bvalid) state <= RESP;
                // hold response until execute takes it
                RESP:    if (resp_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (req_fire) begin
            op_q       <= req_op;
            addr_q     <= req_addr;
            wdata_q    <= lane_wdata;
            strb_q     <= lane_strb;
            // stores and faults answer with zero
            resp_rdata <= '0;
        end else if (state == RD_DATA && bus.rvalid) begin
            resp_rdata <= load_data;
        end
    end

    assign resp_valid  = (state == RESP);

    // bus drive straight from state, stable while waiting for ready
    assign bus.araddr  = addr_q;
    assign bus.arvalid = (state == RD_ADDR);
    assign bus.rready  = (state == RD_DATA);
    assign bus.awaddr  = addr_q;
    assign bus.awvalid = (state == WR_REQ);
    assign bus.wdata   = wdata_q;
    assign bus.wstrb   = strb_q;
    assign bus.wvalid  = (state == WR_REQ);
    assign bus.bready  = (state == WR_RESP);

endmodule

//--- src/axi_lite_if.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

interface axi_lite_if;

    // read address channel
    logic [`LSU_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     arready;

    // read data channel, no rresp
    logic [`LSU_ADDR_W-1:0]   rdata;
    logic                     rvalid;
    logic                     rready;

    // write address channel
    logic [`LSU_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic                     awready;

    // write data channel, one strobe bit per byte lane
    logic [`LSU_ADDR_W-1:0]   wdata;
    logic [`LSU_ADDR_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     wready;

    // write response, always okay
    logic                     bvalid;
    logic                     bready;

    modport master (
        output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  arready, rdata, rvalid, awready, wready, bvalid
    );

    modport slave (
        input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output arready, rdata, rvalid, awready, wready, bvalid
    );

endinterface

//--- src/lsu_pkg.sv
package lsu_pkg;

    // memory request opcodes from execute
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd3,
        LHU = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } lsu_op_e;

    // core request sequencer
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        RD_ADDR = 3'd1,
        RD_DATA = 3'd2,
        WR_REQ  = 3'd3,
        WR_RESP = 3'd4,
        RESP    = 3'd5
    } lsu_state_e;

    // sram read side
    typedef enum logic [1:0] {
        RD_IDLE  = 2'd0,
        RD_WAIT  = 2'd1,
        RD_VALID = 2'd2
    } rd_state_e;

endpackage

//--- src/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// address and data width, one 32-bit word per beat
`define LSU_ADDR_W      32

// sram size in 32-bit words
`define LSU_SRAM_DEPTH  1024

// first byte address mapped onto the array
`define LSU_MEM_BASE    32'h8000_0000

// cycles from ar handshake until rvalid
// must stay at 1 or above
`define LSU_RD_LAT      5

`endif
